/* hw/afifo_pkg.sv */
package afifo_pkg;

	// ====================
	// Default geometry
	// ====================

	parameter int DEF_DATA_W    = 32;	// Word width in bits
	parameter int DEF_DEPTH     = 16;	// Words stored, power of two only
	parameter int DEF_ALMOST_WR = 2;	// Almost-full lead in words
	parameter int DEF_ALMOST_RD = 2;	// Almost-empty lead in words

	// ====================
	// Clock crossing
	// ====================

	// Flops per pointer synchronizer
	// Two is enough at the clock rates this FIFO targets
	parameter int SYNC_STAGES = 2;

	// ====================
	// Helpers
	// ====================

	// Address bits for a given depth
	// Pointers add one wrap bit on top of this
	function automatic int addr_w(input int depth);
		return $clog2(depth);
	endfunction

	// Pointer bits including the wrap bit
	function automatic int ptr_w(input int depth);
		return $clog2(depth) + 1;
	endfunction

endpackage

/* hw/afifo_mem_if.sv */
`timescale 1ns/1ps

interface afifo_mem_if
	import afifo_pkg::*;
#(
	parameter int DATA_W = DEF_DATA_W,	// Word width
	parameter int DEPTH  = DEF_DEPTH	// Words in the array
) ();

	localparam int ADDR_W = addr_w(DEPTH);

	// Write port, wr_clk domain
	logic              we;		// Store strobe
	logic [ADDR_W-1:0] waddr;	// Store address
	logic [DATA_W-1:0] wdata;	// Store data

	// Read port, rd_clk domain
	logic [ADDR_W-1:0] raddr;	// Fetch address
	logic [DATA_W-1:0] rdata;	// Array contents at raddr

	// Write controller side
	modport wr (
		output we,
		output waddr,
		output wdata
	);

	// Read controller side
	modport rd (
		output raddr,
		input  rdata
	);

	// Storage side
	modport ram (
		input  we,
		input  waddr,
		input  wdata,
		input  raddr,
		output rdata
	);

endinterface

/* hw/gray_ptr_sync.sv */
`timescale 1ns/1ps

module gray_ptr_sync
	import afifo_pkg::*;
#(
	parameter int PTR_W = ptr_w(DEF_DEPTH)	// Pointer width incl. wrap bit
) (
	input  logic             clk,		// Destination clock
	input  logic             rst_n,
	input  logic [PTR_W-1:0] gray_in,	// Source pointer in Gray code
	output logic [PTR_W-1:0] bin_out	// Synced pointer in binary
);

	logic [PTR_W-1:0] sync_q [SYNC_STAGES];	// Flop chain

	// ====================
	// Sync chain
	// ====================

	// First stage may go metastable
	// Later stages only see settled values
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < SYNC_STAGES; i++) begin
				sync_q[i] <= '0;
			end
		end else begin
			sync_q[0] <= gray_in;
			for (int i = 1; i < SYNC_STAGES; i++) begin
				sync_q[i] <= sync_q[i-1];
			end
		end
	end

	// ====================
	// Gray to binary
	// ====================

	// Top bit passes through
	// Each lower bit folds in everything above it
	always_comb begin
		bin_out[PTR_W-1] = sync_q[SYNC_STAGES-1][PTR_W-1];
		for (int i = PTR_W - 2; i >= 0; i--) begin
			bin_out[i] = sync_q[SYNC_STAGES-1][i] ^ bin_out[i+1];
		end
	end

endmodule

/* hw/afifo_ram.sv */
`timescale 1ns/1ps

module afifo_ram
	import afifo_pkg::*;
#(
	parameter int DATA_W = DEF_DATA_W,	// Word width
	parameter int DEPTH  = DEF_DEPTH	// Words stored
) (
	input  logic    wr_clk,	// Write clock only
	afifo_mem_if.ram mem	// Both array ports
);

	localparam int ADDR_W = addr_w(DEPTH);

	// Plain register array
	// Maps to distributed RAM
	logic [DATA_W-1:0] store [DEPTH];

	// ====================
	// Write port
	// ====================

	always_ff @(posedge wr_clk) begin
		if (mem.we) begin
			store[mem.waddr] <= mem.wdata;
		end
	end

	// ====================
	// Read port
	// ====================

	// Async read
	// rd_ctrl registers the word on rd_clk
	assign mem.rdata = store[mem.raddr];

	// Writer must stay inside the array
	a_waddr_range: assert property (
		@(posedge wr_clk)
		mem.we |-> (ADDR_W'(mem.waddr) < DEPTH)
	);

endmodule

/* hw/afifo_wr_ctrl.sv */
`timescale 1ns/1ps

module afifo_wr_ctrl
	import afifo_pkg::*;
#(
	parameter int DATA_W    = DEF_DATA_W,
	parameter int DEPTH     = DEF_DEPTH,
	parameter int ALMOST_WR = DEF_ALMOST_WR
) (
	input  logic                    wr_clk,
	input  logic                    rst_n,
	input  logic                    wr_en,			// Write request from upstream
	input  logic [DATA_W-1:0]       din,			// Word to store
	output logic                    full,			// No room left
	output logic                    almost_full,	// Within ALMOST_WR of full
	output logic [ptr_w(DEPTH)-1:0] wr_count,		// Fill level seen by writer
	output logic                    wr_ack,		// Previous edge took a word
	afifo_mem_if.wr                 mem,			// Array write port
	output logic [ptr_w(DEPTH)-1:0] wr_ptr_gray,	// To read domain
	input  logic [ptr_w(DEPTH)-1:0] rd_ptr_bin		// Synced read pointer
);

	localparam int ADDR_W = addr_w(DEPTH);
	localparam int PTR_W  = ptr_w(DEPTH);

	// Thresholds at count width
	localparam logic [PTR_W-1:0] FULL_LEVEL = PTR_W'(DEPTH);
	localparam logic [PTR_W-1:0] AF_LEVEL   = PTR_W'(DEPTH - ALMOST_WR);

	logic [PTR_W-1:0] wr_ptr;	// Binary, with wrap bit on top
	logic             wr_go;	// Write accepted this edge

	// ====================
	// Pointer
	// ====================

	assign wr_go = wr_en & ~full;	// Drop writes while full

	always_ff @(posedge wr_clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
		end else if (wr_go) begin
			wr_ptr <= wr_ptr + 1'b1;
		end
	end

	// Gray copy for the crossing
	// Only one bit moves per increment
	assign wr_ptr_gray = (wr_ptr >> 1) ^ wr_ptr;

	// ====================
	// Flags and count
	// ====================

	// Full when one lap ahead of reader
	// Wrap bits differ and the addresses match
	assign full = (wr_ptr[ADDR_W] != rd_ptr_bin[ADDR_W])
		&& (wr_ptr[ADDR_W-1:0] == rd_ptr_bin[ADDR_W-1:0]);

	assign wr_count    = wr_ptr - rd_ptr_bin;	// Modulo difference
	assign almost_full = wr_count >= AF_LEVEL;

	always_ff @(posedge wr_clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ack <= 1'b0;
		end else begin
			wr_ack <= wr_go;	// One cycle per accepted word
		end
	end

	// Array write port
	assign mem.we    = wr_go;
	assign mem.waddr = wr_ptr[ADDR_W-1:0];
	assign mem.wdata = din;

	// ====================
	// Checks
	// ====================

	// Wrap-bit full test must agree with the count
	a_full_count: assert property (
		@(posedge wr_clk) disable iff (!rst_n)
		full |-> (wr_count == FULL_LEVEL)
	);

	// A blocked write never acknowledges
	a_no_ack_full: assert property (
		@(posedge wr_clk) disable iff (!rst_n)
		(wr_en && full) |=> !wr_ack
	);

endmodule

/* hw/afifo_rd_ctrl.sv */
`timescale 1ns/1ps

module afifo_rd_ctrl
	import afifo_pkg::*;
#(
	parameter int DATA_W    = DEF_DATA_W,
	parameter int DEPTH     = DEF_DEPTH,
	parameter int ALMOST_RD = DEF_ALMOST_RD
) (
	input  logic                    rd_clk,
	input  logic                    rst_n,
	input  logic                    rd_en,			// Read request from consumer
	output logic [DATA_W-1:0]       dout,			// Registered read word
	output logic                    valid,			// dout updated last edge
	output logic                    empty,			// Nothing to read
	output logic                    almost_empty,	// At most ALMOST_RD words left
	output logic [ptr_w(DEPTH)-1:0] rd_count,		// Fill level seen by reader
	afifo_mem_if.rd                 mem,			// Array read port
	output logic [ptr_w(DEPTH)-1:0] rd_ptr_gray,	// To write domain
	input  logic [ptr_w(DEPTH)-1:0] wr_ptr_bin		// Synced write pointer
);

	localparam int ADDR_W = addr_w(DEPTH);
	localparam int PTR_W  = ptr_w(DEPTH);

	// Almost-empty below this level
	localparam logic [PTR_W-1:0] AE_LEVEL = PTR_W'(ALMOST_RD + 1);

	logic [PTR_W-1:0] rd_ptr;	// Binary, with wrap bit on top
	logic             rd_go;	// Read accepted this edge

	// ====================
	// Pointer
	// ====================

	assign rd_go = rd_en & ~empty;	// Ignore reads while empty

	always_ff @(posedge rd_clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_ptr <= '0;
		end else if (rd_go) begin
			rd_ptr <= rd_ptr + 1'b1;
		end
	end

	assign rd_ptr_gray = (rd_ptr >> 1) ^ rd_ptr;	// Crossing copy
	assign mem.raddr   = rd_ptr[ADDR_W-1:0];

	// ====================
	// Flags and count
	// ====================

	// Empty when reader caught up with the synced writer
	assign empty        = (rd_ptr == wr_ptr_bin);
	assign rd_count     = wr_ptr_bin - rd_ptr;	// Modulo difference
	assign almost_empty = rd_count < AE_LEVEL;

	// ====================
	// Output register
	// ====================

	// Word at raddr is captured on the same edge the pointer moves
	always_ff @(posedge rd_clk or negedge rst_n) begin
		if (!rst_n) begin
			dout  <= '0;
			valid <= 1'b0;
		end else begin
			valid <= rd_go;	// One-cycle strobe
			if (rd_go) begin
				dout <= mem.rdata;
			end	// Otherwise hold last word
		end
	end

	// ====================
	// Checks
	// ====================

	// Strobe only follows a real read
	a_valid_cause: assert property (
		@(posedge rd_clk) disable iff (!rst_n)
		valid |-> $past(rd_en && !empty)
	);

	// Count can never pass a full array
	a_count_range: assert property (
		@(posedge rd_clk) disable iff (!rst_n)
		rd_count <= PTR_W'(DEPTH)
	);

endmodule

/* hw/afifo_top.sv */
`timescale 1ns/1ps

module afifo_top
	import afifo_pkg::*;
#(
	parameter int DATA_W    = DEF_DATA_W,
	parameter int DEPTH     = DEF_DEPTH,
	parameter int ALMOST_WR = DEF_ALMOST_WR,
	parameter int ALMOST_RD = DEF_ALMOST_RD
) (
	input  logic                    wr_clk,
	input  logic                    rd_clk,
	input  logic                    rst_n,			// Async, both domains
	// Write side
	input  logic                    wr_en,
	input  logic [DATA_W-1:0]       din,
	// Read side
	input  logic                    rd_en,
	output logic [DATA_W-1:0]       dout,
	// Status
	output logic                    full,
	output logic                    empty,
	output logic                    almost_full,
	output logic                    almost_empty,
	output logic                    wr_ack,
	output logic                    valid,
	output logic [ptr_w(DEPTH)-1:0] wr_count,
	output logic [ptr_w(DEPTH)-1:0] rd_count
);

	localparam int PTR_W = ptr_w(DEPTH);

	// Pointer crossing wires
	logic [PTR_W-1:0] wr_ptr_gray;	// wr_clk domain
	logic [PTR_W-1:0] wr_ptr_sync;	// rd_clk domain
	logic [PTR_W-1:0] rd_ptr_gray;	// rd_clk domain
	logic [PTR_W-1:0] rd_ptr_sync;	// wr_clk domain

	// Array ports
	afifo_mem_if #(
		.DATA_W (DATA_W),
		.DEPTH  (DEPTH)
	) mem_if ();

	// ====================
	// Write domain
	// ====================

	afifo_wr_ctrl #(
		.DATA_W    (DATA_W),
		.DEPTH     (DEPTH),
		.ALMOST_WR (ALMOST_WR)
	) wr_ctrl_i (
		.wr_clk      (wr_clk),
		.rst_n       (rst_n),
		.wr_en       (wr_en),
		.din         (din),
		.full        (full),
		.almost_full (almost_full),
		.wr_count    (wr_count),
		.wr_ack      (wr_ack),
		.mem         (mem_if.wr),
		.wr_ptr_gray (wr_ptr_gray),
		.rd_ptr_bin  (rd_ptr_sync)
	);

	// Read pointer into write domain
	gray_ptr_sync #(
		.PTR_W (PTR_W)
	) rd_to_wr_sync (
		.clk     (wr_clk),
		.rst_n   (rst_n),
		.gray_in (rd_ptr_gray),
		.bin_out (rd_ptr_sync)
	);

	afifo_ram #(
		.DATA_W (DATA_W),
		.DEPTH  (DEPTH)
	) ram_i (
		.wr_clk (wr_clk),
		.mem    (mem_if.ram)
	);

	// ====================
	// Read domain
	// ====================

	afifo_rd_ctrl #(
		.DATA_W    (DATA_W),
		.DEPTH     (DEPTH),
		.ALMOST_RD (ALMOST_RD)
	) rd_ctrl_i (
		.rd_clk       (rd_clk),
		.rst_n        (rst_n),
		.rd_en        (rd_en),
		.dout         (dout),
		.valid        (valid),
		.empty        (empty),
		.almost_empty (almost_empty),
		.rd_count     (rd_count),
		.mem          (mem_if.rd),
		.rd_ptr_gray  (rd_ptr_gray),
		.wr_ptr_bin   (wr_ptr_sync)
	);

	// Write pointer into read domain
	gray_ptr_sync #(
		.PTR_W (PTR_W)
	) wr_to_rd_sync (
		.clk     (rd_clk),
		.rst_n   (rst_n),
		.gray_in (wr_ptr_gray),
		.bin_out (wr_ptr_sync)
	);

endmodule

/* sim/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen #(
	parameter realtime PERIOD = 8.0	// Full period in ns
) (
	output logic clk
);

	// Starts low, first rising edge at half a period
	initial begin
		clk = 1'b0;
		forever begin
			#(PERIOD / 2.0);
			clk = ~clk;
		end
	end

endmodule

/* sim/afifo_tb.sv */
`timescale 1ns/1ps

module afifo_tb;

	localparam int DATA_W    = 32;
	localparam int DEPTH     = 16;
	localparam int PTR_W     = $clog2(DEPTH) + 1;
	localparam logic [31:0] LFSR_POLY = 32'h8020_0003;	// x^32+x^22+x^2+x+1

	// Phase lengths in rd_clk cycles, wr_clk phases scaled by 10/8
	localparam int RESET_LEN = 10;
	localparam int FILL_LEN  = 60;	// 16 writes, 8 dropped, settle
	localparam int DRAIN_LEN = 50;
	localparam int RAND_LEN  = 500;	// 400 wr_clk cycles
	localparam int FINAL_LEN = 60;
	localparam int LIMIT     = 2 * (RESET_LEN + FILL_LEN + DRAIN_LEN + RAND_LEN + FINAL_LEN);

	logic wr_clk, rd_clk, rst_n;
	logic wr_en, rd_en;
	logic [DATA_W-1:0] din, dout;
	logic full, empty, almost_full, almost_empty, wr_ack, valid;
	logic [PTR_W-1:0] wr_count, rd_count;

	logic [31:0] lfsr = 32'd50;	// Seed
	logic hold_full, hold_empty, idle_check;	// Windows for the sticky and idle checks
	int cycles = 0;
	int err_data = 0, err_ack = 0, err_strobe = 0, err_flags = 0;
	int err_counts = 0, err_reset = 0, err_timeout = 0;

	// Scoreboard ring, writer owns wr_idx and reader owns rd_idx
	logic [DATA_W-1:0] sb_mem [1024];
	logic [9:0] wr_idx = '0, rd_idx = '0;
	logic [9:0] sb_count;
	logic [DATA_W-1:0] exp_word;
	logic [7:0] wr_stat;
	logic [39:0] rd_stat;

	tb_clk_gen #(.PERIOD(8.0)) rd_clk_gen (.clk(rd_clk));
	tb_clk_gen #(.PERIOD(10.0)) wr_clk_gen (.clk(wr_clk));

	afifo_top #(
		.DATA_W    (DATA_W),
		.DEPTH     (DEPTH),
		.ALMOST_WR (2),
		.ALMOST_RD (2)
	) afifo_top_i (
		.wr_clk (wr_clk), .rd_clk (rd_clk), .rst_n (rst_n),
		.wr_en (wr_en), .din (din), .rd_en (rd_en), .dout (dout),
		.full (full), .empty (empty), .almost_full (almost_full),
		.almost_empty (almost_empty), .wr_ack (wr_ack), .valid (valid),
		.wr_count (wr_count), .rd_count (rd_count)
	);

	assign sb_count = wr_idx - rd_idx;	// Words in flight
	assign exp_word = sb_mem[rd_idx];	// Oldest word
	assign wr_stat  = {wr_ack, full, almost_full, wr_count};
	assign rd_stat  = {valid, empty, almost_empty, rd_count, dout};

	// ====================
	// Scoreboard
	// ====================

	always @(posedge wr_clk) begin
		if (rst_n && wr_en && !full) begin	// Accepted write
			sb_mem[wr_idx] <= din;
			wr_idx <= wr_idx + 1'b1;
		end
	end

	always @(posedge rd_clk) begin
		if (valid) begin
			rd_idx <= rd_idx + 1'b1;	// Pop on strobe
		end
	end

	// ====================
	// Checks
	// ====================

	a_order: assert property (@(posedge rd_clk) disable iff (!rst_n) valid |-> dout == exp_word)
		else begin
			err_data++;
			$display("Mismatch order: expected %h actual %h", $sampled(exp_word), $sampled(dout));
		end
	a_no_extra: assert property (@(posedge rd_clk) disable iff (!rst_n) valid |-> sb_count != 0)
		else begin
			err_data++;
			$display("Read strobe seen with no word left in the scoreboard");
		end
	a_ack: assert property (@(posedge wr_clk) disable iff (!rst_n)
		wr_ack == $past(wr_en && !full))
		else begin
			err_ack++;
			$display("Mismatch wr_ack: expected %b actual %b", !$sampled(wr_ack), $sampled(wr_ack));
		end
	a_strobe: assert property (@(posedge rd_clk) disable iff (!rst_n)
		valid == $past(rd_en && !empty))
		else begin
			err_strobe++;
			$display("Mismatch valid: expected %b actual %b", !$sampled(valid), $sampled(valid));
		end
	a_hold_full: assert property (@(posedge wr_clk) hold_full |-> full && wr_count == DEPTH)
		else begin
			err_flags++;
			$display("Mismatch hold_full: expected %h actual %h", {1'b1, 5'd16},
				{$sampled(full), $sampled(wr_count)});
		end
	a_hold_empty: assert property (@(posedge rd_clk) hold_empty |-> empty && rd_count == 0)
		else begin
			err_flags++;
			$display("Mismatch hold_empty: expected %h actual %h", {1'b1, 5'd0},
				{$sampled(empty), $sampled(rd_count)});
		end
	a_almost_full: assert property (@(posedge wr_clk) almost_full == (wr_count >= 14))
		else begin
			err_flags++;
			$display("Mismatch almost_full: expected %b actual %b",
				$sampled(wr_count) >= 14, $sampled(almost_full));
		end
	a_almost_empty: assert property (@(posedge rd_clk) almost_empty == (rd_count < 3))
		else begin
			err_flags++;
			$display("Mismatch almost_empty: expected %b actual %b",
				$sampled(rd_count) < 3, $sampled(almost_empty));
		end
	a_wr_bound: assert property (@(posedge wr_clk) wr_count <= DEPTH)
		else begin
			err_counts++;
			$display("Mismatch wr_bound: expected at most 16 actual %0d", $sampled(wr_count));
		end
	a_rd_bound: assert property (@(posedge rd_clk) rd_count <= DEPTH)
		else begin
			err_counts++;
			$display("Mismatch rd_bound: expected at most 16 actual %0d", $sampled(rd_count));
		end
	a_idle_rd: assert property (@(posedge rd_clk) idle_check |-> rd_count == sb_count)
		else begin
			err_counts++;
			$display("Mismatch idle_rd: expected %0d actual %0d", $sampled(sb_count),
				$sampled(rd_count));
		end
	a_idle_wr: assert property (@(posedge wr_clk) idle_check |-> wr_count == sb_count)
		else begin
			err_counts++;
			$display("Mismatch idle_wr: expected %0d actual %0d", $sampled(sb_count),
				$sampled(wr_count));
		end
	// During reset and on the first edge after it
	a_reset_wr: assert property (@(posedge wr_clk) (!rst_n || $rose(rst_n)) |-> wr_stat == 8'h00)
		else begin
			err_reset++;
			$display("Mismatch reset_wr: expected %h actual %h", 8'h00, $sampled(wr_stat));
		end
	a_reset_rd: assert property (@(posedge rd_clk)
		(!rst_n || $rose(rst_n)) |-> rd_stat == {3'b011, 37'd0})
		else begin
			err_reset++;
			$display("Mismatch reset_rd: expected %h actual %h", {3'b011, 37'd0},
				$sampled(rd_stat));
		end

	// ====================
	// Helpers
	// ====================

	// Galois LFSR, one step per bit taken
	function automatic logic [31:0] next_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_POLY) : (lfsr >> 1);
		end
		return r;
	endfunction

	task automatic fill_until_full();
		@(negedge wr_clk);
		while (!full) begin
			wr_en = 1'b1;
			din   = next_bits(32);
			@(negedge wr_clk);
		end
		hold_full = 1'b1;	// Reader idle, full must stay
		repeat (8) begin
			din = next_bits(32);	// Dropped writes
			@(negedge wr_clk);
		end
		wr_en     = 1'b0;
		hold_full = 1'b0;
	endtask

	task automatic drain_until_empty();
		@(negedge rd_clk);
		while (!empty) begin
			rd_en = 1'b1;
			@(negedge rd_clk);
		end
		hold_empty = 1'b1;	// Writer idle, empty must stay
		repeat (8) @(negedge rd_clk);	// Reads while empty
		rd_en      = 1'b0;
		hold_empty = 1'b0;
	endtask

	// Both sides idle, then counts must match the scoreboard
	task automatic settle_check();
		repeat (5) @(negedge wr_clk);
		@(negedge rd_clk);
		idle_check = 1'b1;
		repeat (3) @(negedge rd_clk);
		idle_check = 1'b0;
	endtask

	task automatic write_random();
		repeat (400) begin
			@(negedge wr_clk);
			wr_en = |next_bits(2);	// About 75 percent
			din   = next_bits(32);
		end
		@(negedge wr_clk);
		wr_en = 1'b0;
	endtask

	task automatic read_random();
		logic [31:0] b;
		repeat (400) begin
			@(negedge rd_clk);
			b     = next_bits(1);
			rd_en = b[0];	// About 50 percent
		end
		@(negedge rd_clk);
		rd_en = 1'b0;
	endtask

	task automatic report_and_finish();
		int total;
		total = err_data + err_ack + err_strobe + err_flags + err_counts + err_reset + err_timeout;
		$display("Errors: data=%0d ack=%0d strobe=%0d flags=%0d counts=%0d reset=%0d timeout=%0d",
			err_data, err_ack, err_strobe, err_flags, err_counts, err_reset, err_timeout);
		if (total == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	endtask

	// ====================
	// Watchdog
	// ====================

	always @(posedge rd_clk) begin
		cycles <= cycles + 1;
		if (cycles == LIMIT) begin
			err_timeout++;
			$display("Timeout: run did not finish within %0d rd_clk cycles", LIMIT);
			report_and_finish();
		end
	end

	// ====================
	// Stimulus
	// ====================

	initial begin
		wr_en      = 1'b0;
		rd_en      = 1'b0;
		din        = '0;
		rst_n      = 1'b0;
		hold_full  = 1'b0;
		hold_empty = 1'b0;
		idle_check = 1'b0;
		repeat (5) @(negedge rd_clk);
		rst_n = 1'b1;
		repeat (3) @(negedge rd_clk);	// Reset state checked meanwhile
		fill_until_full();
		settle_check();
		drain_until_empty();
		settle_check();
		fork
			write_random();
			read_random();
		join
		settle_check();
		drain_until_empty();	// Final drain
		settle_check();
		report_and_finish();
	end

endmodule

/* project.f */
hw/afifo_pkg.sv
hw/afifo_mem_if.sv
hw/gray_ptr_sync.sv
hw/afifo_ram.sv
hw/afifo_wr_ctrl.sv
hw/afifo_rd_ctrl.sv
hw/afifo_top.sv
sim/tb_clk_gen.sv
sim/afifo_tb.sv
